//--- include/rtc_ctrl_settings.svh
`ifndef RTC_CTRL_SETTINGS_SVH
`define RTC_CTRL_SETTINGS_SVH

// bus slot timing
`define RTC_SLOT_CLOCKS   32      // clocks per bus slot
`define RTC_SLOT_W        5       // slot counter width
`define RTC_STEP_W        5       // step counter width
`define RTC_BYTE_W        8       // multiplexed bus width

// route lengths in slots
`define RTC_INIT_STEPS    28
`define RTC_READ_STEPS    14
`define RTC_SET_STEPS     8

// chip register map
`define RTC_ADDR_CTRL     8'h00
`define RTC_ADDR_STATUS   8'h02
`define RTC_ADDR_CONFIG   8'h10   // only touched during init
`define RTC_ADDR_CENTI    8'h20   // hundredths of a second
`define RTC_ADDR_SEC      8'h21
`define RTC_ADDR_MIN      8'h22
`define RTC_ADDR_HOUR     8'h23
`define RTC_ADDR_DAY      8'h24
`define RTC_ADDR_MONTH    8'h25
`define RTC_ADDR_YEAR     8'h26
`define RTC_ADDR_WEEKDAY  8'h27
`define RTC_ADDR_WEEK     8'h28

// commands and fixed data bytes
`define RTC_CMD_READ      8'hF0   // clock -> ram
`define RTC_CMD_TRANSFER  8'hF1   // ram -> clock
`define RTC_INIT_FLAG     8'h10
`define RTC_CONFIG_VALUE  8'hD2

`endif

//--- logic/rtc_ctrl_pkg.sv
package rtc_ctrl_pkg;

	typedef enum logic [1:0] {
		ROUTE_INIT,
		ROUTE_READ,
		ROUTE_SET_TIME,
		ROUTE_SET_DATE
	} route_t;

	// display state, visible on the mode output
	typedef enum logic [1:0] {
		MODE_RUN      = 2'd0,
		MODE_SET_TIME = 2'd1,
		MODE_SET_DATE = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		REQ_NONE,
		REQ_TIME,
		REQ_DATE
	} request_t;

	typedef enum logic [1:0] {
		XFER_ADDR,
		XFER_WRITE,
		XFER_READ,
		XFER_STROBE   // data phase, previous byte stays on the bus
	} xfer_t;

	typedef enum logic [3:0] {
		SEL_NONE  = 4'd0,
		SEL_SEC   = 4'd1,
		SEL_MIN   = 4'd2,
		SEL_HOUR  = 4'd3,
		SEL_DAY   = 4'd4,
		SEL_MONTH = 4'd5,
		SEL_YEAR  = 4'd6,
		SEL_DUMMY = 4'd10   // discard slot after the read command
	} reg_sel_t;

endpackage

//--- logic/rtc_step_if.sv
`timescale 1ns/10ps
`include "rtc_ctrl_settings.svh"

// one bus transfer per slot, no back-pressure
interface rtc_step_if
	import rtc_ctrl_pkg::*;
();

	logic                    valid;  // one clock per slot
	xfer_t                   kind;
	logic [`RTC_BYTE_W-1:0]  value;  // address or constant data
	reg_sel_t                sel;    // read target or write source

	modport source (output valid, kind, value, sel);
	modport sink (input valid, kind, value, sel);

endinterface

//--- logic/rtc_step_table.sv
`timescale 1ns/10ps
`include "rtc_ctrl_settings.svh"

module rtc_step_table
	import rtc_ctrl_pkg::*;
(
	input  route_t                  route,
	input  logic [`RTC_STEP_W-1:0]  step,
	output xfer_t                   kind,
	output logic [`RTC_BYTE_W-1:0]  value,
	output reg_sel_t                sel,
	output logic                    last
);

	// even steps carry an address, odd steps the data phase
	always_comb
	begin
		kind  = step[0] ? XFER_WRITE : XFER_ADDR;
		value = '0;
		sel   = SEL_NONE;
		last  = 1'b0;
		case (route)
			////////////////////////////////////////
			// init: clear the clock, then latch it
			////////////////////////////////////////
			ROUTE_INIT:
			begin
				last = (step == (`RTC_STEP_W)'(`RTC_INIT_STEPS - 1));
				case (step)
					0, 2: value = `RTC_ADDR_STATUS;
					1:    value = `RTC_INIT_FLAG;
					4:    value = `RTC_ADDR_CONFIG;
					5:    value = `RTC_CONFIG_VALUE;
					6:    value = `RTC_ADDR_CTRL;
					8:    value = `RTC_ADDR_CENTI;
					10:   value = `RTC_ADDR_SEC;
					12:   value = `RTC_ADDR_MIN;
					14:   value = `RTC_ADDR_HOUR;
					16:   value = `RTC_ADDR_DAY;
					18:   value = `RTC_ADDR_MONTH;
					20:   value = `RTC_ADDR_YEAR;
					22:   value = `RTC_ADDR_WEEKDAY;
					24:   value = `RTC_ADDR_WEEK;
					26:   value = `RTC_CMD_TRANSFER;
					27:   kind  = XFER_STROBE;
					default: value = '0;   // remaining data phases write 00
				endcase
			end
			////////////////////////////////////////
			// read: snapshot, then fetch each register
			////////////////////////////////////////
			ROUTE_READ:
			begin
				last = (step == (`RTC_STEP_W)'(`RTC_READ_STEPS - 1));
				if (step[0])
					kind = XFER_READ;
				case (step)
					0:  value = `RTC_CMD_READ;
					1:  sel   = SEL_DUMMY;
					2:  value = `RTC_ADDR_SEC;
					3:  sel   = SEL_SEC;
					4:  value = `RTC_ADDR_MIN;
					5:  sel   = SEL_MIN;
					6:  value = `RTC_ADDR_HOUR;
					7:  sel   = SEL_HOUR;
					8:  value = `RTC_ADDR_DAY;
					9:  sel   = SEL_DAY;
					10: value = `RTC_ADDR_MONTH;
					11: sel   = SEL_MONTH;
					12: value = `RTC_ADDR_YEAR;
					13: sel   = SEL_YEAR;
					default: sel = SEL_NONE;
				endcase
			end
			default:   // set time or set date
			begin
				last = (step == (`RTC_STEP_W)'(`RTC_SET_STEPS - 1));
				case (step)
					0: value = (route == ROUTE_SET_TIME) ? `RTC_ADDR_SEC : `RTC_ADDR_DAY;
					1: sel   = (route == ROUTE_SET_TIME) ? SEL_SEC : SEL_DAY;
					2: value = (route == ROUTE_SET_TIME) ? `RTC_ADDR_MIN : `RTC_ADDR_MONTH;
					3: sel   = (route == ROUTE_SET_TIME) ? SEL_MIN : SEL_MONTH;
					4: value = (route == ROUTE_SET_TIME) ? `RTC_ADDR_HOUR : `RTC_ADDR_YEAR;
					5: sel   = (route == ROUTE_SET_TIME) ? SEL_HOUR : SEL_YEAR;
					6: value = `RTC_CMD_TRANSFER;
					7: kind  = XFER_STROBE;
					default: kind = XFER_ADDR;
				endcase
			end
		endcase
	end

endmodule

//--- logic/rtc_route_sequencer.sv
`timescale 1ns/10ps
`include "rtc_ctrl_settings.svh"

module rtc_route_sequencer
	import rtc_ctrl_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  route_t             next_route,
	output logic               route_done,
	rtc_step_if.source         step
);

	logic [`RTC_SLOT_W-1:0]  slot_cnt;   // clock within the slot
	logic [`RTC_STEP_W-1:0]  step_cnt;   // transfer within the route
	route_t                  route;
	logic                    slot_end;
	logic                    last;

	rtc_step_table table_i (
		.route (route),
		.step  (step_cnt),
		.kind  (step.kind),
		.value (step.value),
		.sel   (step.sel),
		.last  (last)
	);

	assign slot_end   = (slot_cnt == (`RTC_SLOT_W)'(`RTC_SLOT_CLOCKS - 1));
	assign step.valid = slot_end;
	assign route_done = slot_end & last;   // next route picked on the same edge

	////////////////////////////////////////
	// slot and step counters
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			slot_cnt <= '0;
			step_cnt <= '0;
			route    <= ROUTE_INIT;
		end
		else
		begin
			if (slot_end)
				slot_cnt <= '0;
			else
				slot_cnt <= slot_cnt + 1'b1;

			if (slot_end)
			begin
				if (last)
				begin
					step_cnt <= '0;
					route    <= next_route;   // no idle slot between routes
				end
				else
					step_cnt <= step_cnt + 1'b1;
			end
		end
	end

endmodule

//--- logic/rtc_mode_decode.sv
`timescale 1ns/10ps

module rtc_mode_decode
	import rtc_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic [1:0]  swt,
	input  logic        route_done,
	output route_t      next_route,
	output mode_t       mode
);

	request_t pending;   // set request waiting for the switch to return to 00

	// a pending request runs once the switch is back at 00
	always_comb
	begin
		next_route = ROUTE_READ;
		if (swt == 2'b00)
		begin
			case (pending)
				REQ_TIME: next_route = ROUTE_SET_TIME;
				REQ_DATE: next_route = ROUTE_SET_DATE;
				default:  next_route = ROUTE_READ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pending <= REQ_NONE;
			mode    <= MODE_RUN;
		end
		else
		begin
			case (swt)
				2'b01:   pending <= REQ_TIME;
				2'b10:   pending <= REQ_DATE;
				default:
				begin
					if (route_done && next_route != ROUTE_READ)
						pending <= REQ_NONE;   // write route taken
				end
			endcase
			if (route_done && next_route == ROUTE_READ)
			begin
				case (swt)
					2'b00:   mode <= MODE_RUN;
					2'b01:   mode <= MODE_SET_TIME;
					2'b10:   mode <= MODE_SET_DATE;
					default: mode <= mode;   // both switches up, hold
				endcase
			end
		end
	end

endmodule

//--- logic/rtc_bus_output.sv
`timescale 1ns/10ps
`include "rtc_ctrl_settings.svh"

module rtc_bus_output
	import rtc_ctrl_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	rtc_step_if.sink                step,
	input  logic [`RTC_BYTE_W-1:0]  sec,
	input  logic [`RTC_BYTE_W-1:0]  min,
	input  logic [`RTC_BYTE_W-1:0]  hour,
	input  logic [`RTC_BYTE_W-1:0]  day,
	input  logic [`RTC_BYTE_W-1:0]  month,
	input  logic [`RTC_BYTE_W-1:0]  year,
	output logic                    dato,
	output logic                    read,
	output logic [`RTC_BYTE_W-1:0]  addr_date,
	output logic [3:0]              reg_select,
	output logic                    bus_enable
);

	logic [`RTC_BYTE_W-1:0] write_data;

	// init writes carry their constant in the table byte
	always_comb
	begin
		case (step.sel)
			SEL_SEC:   write_data = sec;
			SEL_MIN:   write_data = min;
			SEL_HOUR:  write_data = hour;
			SEL_DAY:   write_data = day;
			SEL_MONTH: write_data = month;
			SEL_YEAR:  write_data = year;
			default:   write_data = step.value;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			dato       <= 1'b0;
			read       <= 1'b0;
			addr_date  <= '0;
			reg_select <= '0;
			bus_enable <= 1'b0;
		end
		else if (step.valid)
		begin
			dato       <= (step.kind != XFER_ADDR);
			read       <= (step.kind == XFER_READ);
			bus_enable <= 1'b1;   // stays up from the first transfer on
			case (step.kind)
				XFER_ADDR:  addr_date <= step.value;
				XFER_WRITE: addr_date <= write_data;
				default:    addr_date <= addr_date;   // strobe and read keep the byte
			endcase
			if (step.kind == XFER_READ)
				reg_select <= step.sel;
		end
	end

endmodule

//--- logic/rtc_ctrl.sv
`timescale 1ns/10ps
`include "rtc_ctrl_settings.svh"

module rtc_ctrl
	import rtc_ctrl_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic [1:0]              swt,
	input  logic [`RTC_BYTE_W-1:0]  sec,
	input  logic [`RTC_BYTE_W-1:0]  min,
	input  logic [`RTC_BYTE_W-1:0]  hour,
	input  logic [`RTC_BYTE_W-1:0]  day,
	input  logic [`RTC_BYTE_W-1:0]  month,
	input  logic [`RTC_BYTE_W-1:0]  year,
	output logic                    dato,
	output logic                    read,
	output logic                    bus_enable,
	output logic [`RTC_BYTE_W-1:0]  addr_date,
	output logic [3:0]              reg_select,
	output logic [1:0]              mode
);

	route_t next_route;
	logic   route_done;

	rtc_step_if step ();

	rtc_mode_decode decode_i (
		.clk        (clk),
		.reset      (reset),
		.swt        (swt),
		.route_done (route_done),
		.next_route (next_route),
		.mode       (mode)
	);

	rtc_route_sequencer sequencer_i (
		.clk        (clk),
		.reset      (reset),
		.next_route (next_route),
		.route_done (route_done),
		.step       (step.source)
	);

	rtc_bus_output bus_i (
		.clk        (clk),
		.reset      (reset),
		.step       (step.sink),
		.sec        (sec),
		.min        (min),
		.hour       (hour),
		.day        (day),
		.month      (month),
		.year       (year),
		.dato       (dato),
		.read       (read),
		.addr_date  (addr_date),
		.reg_select (reg_select),
		.bus_enable (bus_enable)
	);

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
(
	output logic clk
);

	localparam int HALF_PERIOD = 4;   // 8 ns period

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

endmodule

//--- verification/rtc_ctrl_tb.sv
`timescale 1ns/10ps
`include "rtc_ctrl_settings.svh"

module rtc_ctrl_tb;

	localparam logic [1:0] R_INIT = 2'd0;
	localparam logic [1:0] R_READ = 2'd1;
	localparam logic [1:0] R_TIME = 2'd2;
	localparam logic [1:0] R_DATE = 2'd3;
	localparam logic [1:0] P_NONE = 2'd0;
	localparam logic [1:0] P_TIME = 2'd1;
	localparam logic [1:0] P_DATE = 2'd2;
	localparam int CYCLE_LIMIT = 7000;   // about 185 slots of test plus margin

	logic                    clk;
	logic                    reset;
	logic [1:0]              swt;
	logic [`RTC_BYTE_W-1:0]  sec;
	logic [`RTC_BYTE_W-1:0]  min;
	logic [`RTC_BYTE_W-1:0]  hour;
	logic [`RTC_BYTE_W-1:0]  day;
	logic [`RTC_BYTE_W-1:0]  month;
	logic [`RTC_BYTE_W-1:0]  year;
	logic                    dato;
	logic                    read;
	logic                    bus_enable;
	logic [`RTC_BYTE_W-1:0]  addr_date;
	logic [3:0]              reg_select;
	logic [1:0]              mode;

	logic [31:0] rng;         // xorshift state
	logic [1:0]  m_route;     // reference model state
	logic [1:0]  m_pending;
	logic [1:0]  m_mode;
	int          m_step;
	logic        e_dato;      // expected outputs
	logic        e_read;
	logic        e_enable;
	logic [7:0]  e_byte;
	logic [3:0]  e_sel;
	int          route_runs [4];
	int          run_cycle;
	int          checks;
	int          errors;
	int          cycle_count = 0;
	logic [7:0]  init_addr [14];
	logic [7:0]  init_data [14];
	logic [7:0]  read_addr [7];
	logic [3:0]  read_sel [7];

	tb_clock_gen clock_i (.clk(clk));

	rtc_ctrl uut (
		.clk        (clk),
		.reset      (reset),
		.swt        (swt),
		.sec        (sec),
		.min        (min),
		.hour       (hour),
		.day        (day),
		.month      (month),
		.year       (year),
		.dato       (dato),
		.read       (read),
		.bus_enable (bus_enable),
		.addr_date  (addr_date),
		.reg_select (reg_select),
		.mode       (mode)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] write_source(input logic [1:0] route, input int pair);
		case (pair)
			0:       return (route == R_TIME) ? sec : day;
			1:       return (route == R_TIME) ? min : month;
			default: return (route == R_TIME) ? hour : year;
		endcase
	endfunction

	////////////////////////////////////////
	// reference transfer lists
	////////////////////////////////////////
	task automatic build_tables();
		init_addr[0] = `RTC_ADDR_STATUS;
		init_data[0] = `RTC_INIT_FLAG;
		init_addr[1] = `RTC_ADDR_STATUS;
		init_data[1] = 8'h00;
		init_addr[2] = `RTC_ADDR_CONFIG;
		init_data[2] = `RTC_CONFIG_VALUE;
		init_addr[3] = `RTC_ADDR_CTRL;
		init_data[3] = 8'h00;
		for (int i = 0; i < 9; i++)
		begin
			init_addr[4 + i] = `RTC_ADDR_CENTI + 8'(i);   // hundredths up to week number
			init_data[4 + i] = 8'h00;
		end
		init_addr[13] = `RTC_CMD_TRANSFER;
		read_addr[0] = `RTC_CMD_READ;
		read_sel[0]  = 4'd10;   // dummy read after the command
		for (int i = 1; i < 7; i++)
		begin
			read_addr[i] = `RTC_ADDR_SEC + 8'(i - 1);
			read_sel[i]  = 4'(i);
		end
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		errors++;
		$display("Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	// route end and next-route choice
	task automatic finish_route();
		route_runs[m_route] = route_runs[m_route] + 1;
		m_step = 0;
		if (swt == 2'b00 && m_pending == P_TIME)
		begin
			m_route   = R_TIME;
			m_pending = P_NONE;
		end
		else if (swt == 2'b00 && m_pending == P_DATE)
		begin
			m_route   = R_DATE;
			m_pending = P_NONE;
		end
		else
		begin
			m_route = R_READ;
			if (swt != 2'b11)
				m_mode = swt;   // 11 keeps the mode
		end
	endtask

	// next expected transfer at a slot end
	task automatic advance_model();
		int   pair;
		int   len;
		logic odd;
		pair     = m_step / 2;
		odd      = (m_step % 2) == 1;
		e_dato   = odd;
		e_read   = 1'b0;
		e_enable = 1'b1;
		case (m_route)
			R_INIT:
			begin
				len = `RTC_INIT_STEPS;
				if (!odd)
					e_byte = init_addr[pair];
				else if (m_step != len - 1)
					e_byte = init_data[pair];   // final data phase is a strobe
			end
			R_READ:
			begin
				len = `RTC_READ_STEPS;
				if (!odd)
					e_byte = read_addr[pair];
				else
				begin
					e_read = 1'b1;
					e_sel  = read_sel[pair];
				end
			end
			default:
			begin
				len = `RTC_SET_STEPS;
				if (m_step == len - 2)
					e_byte = `RTC_CMD_TRANSFER;
				else if (!odd)
					e_byte = ((m_route == R_TIME) ? `RTC_ADDR_SEC : `RTC_ADDR_DAY) + 8'(pair);
				else if (m_step != len - 1)
					e_byte = write_source(m_route, pair);
			end
		endcase
		if (m_step == len - 1)
			finish_route();
		else
			m_step++;
	endtask

	task automatic check_outputs();
		checks++;
		assert (dato === e_dato)
			else report_mismatch("dato", 8'(e_dato), 8'(dato));
		assert (read === e_read)
			else report_mismatch("read", 8'(e_read), 8'(read));
		assert (bus_enable === e_enable)
			else report_mismatch("bus_enable", 8'(e_enable), 8'(bus_enable));
		assert (addr_date === e_byte)
			else report_mismatch("addr_date", e_byte, addr_date);
		assert (reg_select === e_sel)
			else report_mismatch("reg_select", 8'(e_sel), 8'(reg_select));
		assert (mode === m_mode)
			else report_mismatch("mode", 8'(m_mode), 8'(mode));
	endtask

	task automatic drive_data();
		rng   = xorshift32(rng);
		sec   = rng[7:0];
		min   = rng[15:8];
		hour  = rng[23:16];
		day   = rng[31:24];
		rng   = xorshift32(rng);
		month = rng[7:0];
		year  = rng[15:8];
	endtask

	// one clock: model update, output check, new inputs
	task automatic tick();
		@(negedge clk);
		if (!reset)
		begin
			run_cycle++;
			if (run_cycle % `RTC_SLOT_CLOCKS == 0)
				advance_model();
			if (swt == 2'b01)
				m_pending = P_TIME;
			else if (swt == 2'b10)
				m_pending = P_DATE;
		end
		check_outputs();
		drive_data();
	endtask

	task automatic wait_runs(input logic [1:0] route, input int count);
		while (route_runs[route] < count)
			tick();
	endtask

	task automatic wait_mode(input logic [1:0] value);
		while (mode !== value)
			tick();
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	initial
	begin
		reset      = 1'b1;
		swt        = 2'b00;
		sec        = '0;
		min        = '0;
		hour       = '0;
		day        = '0;
		month      = '0;
		year       = '0;
		rng        = 32'd65;
		m_route    = R_INIT;
		m_step     = 0;
		m_pending  = P_NONE;
		m_mode     = 2'd0;
		e_dato     = 1'b0;
		e_read     = 1'b0;
		e_enable   = 1'b0;
		e_byte     = '0;
		e_sel      = '0;
		route_runs = '{0, 0, 0, 0};
		run_cycle  = 0;
		checks     = 0;
		errors     = 0;
		build_tables();
		repeat (10) tick();
		reset = 1'b0;
		wait_runs(R_READ, 1);   // init, then one read route

		swt = 2'b01;   // set time across a route boundary
		wait_mode(2'd1);
		repeat (3 * `RTC_SLOT_CLOCKS) tick();
		swt = 2'b00;
		wait_runs(R_TIME, 1);
		wait_runs(R_READ, route_runs[R_READ] + 1);

		swt = 2'b10;   // set date
		wait_mode(2'd2);
		repeat (3 * `RTC_SLOT_CLOCKS) tick();
		swt = 2'b00;
		wait_runs(R_DATE, 1);
		wait_runs(R_READ, route_runs[R_READ] + 1);

		swt = 2'b10;   // date request left pending while both switches are up
		wait_mode(2'd2);
		swt = 2'b11;
		wait_runs(R_READ, route_runs[R_READ] + 2);

		assert (mode === 2'd2)
			else report_failure("mode did not hold its value with the switch at 11");
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count == CYCLE_LIMIT)
		begin
			$display("Timeout: test sequence did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Summary: %0d checks, %0d errors", checks, errors);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

//--- rtc_ctrl.f
+incdir+include
logic/rtc_ctrl_pkg.sv
logic/rtc_step_if.sv
logic/rtc_step_table.sv
logic/rtc_route_sequencer.sv
logic/rtc_mode_decode.sv
logic/rtc_bus_output.sv
logic/rtc_ctrl.sv
verification/tb_clock_gen.sv
verification/rtc_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the RTC controller testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module rtc_ctrl_tb -Mdir "$BUILD_DIR" -f rtc_ctrl.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

"./$BUILD_DIR/Vrtc_ctrl_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG_FILE"; then
	exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
